// ==== design/swu_config.svh ====
`ifndef SWU_CONFIG_SVH
`define SWU_CONFIG_SVH

////////////////////
// base parameters
////////////////////

// channels carried in one input word
`define SWU_SIMD 4
// bits per channel
`define SWU_PREC 2
`define SWU_CHANNELS 8
// input feature map
`define SWU_IFM_W 5
`define SWU_IFM_H 5
// square kernel and stride
`define SWU_K 3
`define SWU_STRIDE 1
// circular buffer depth in words of at least K * IFM_W * EFF_CH
`define SWU_BUF_SIZE 32

////////////////////
// derived values
////////////////////

`define SWU_EFF_CH (`SWU_CHANNELS / `SWU_SIMD)
`define SWU_OFM_W (((`SWU_IFM_W - `SWU_K) / `SWU_STRIDE) + 1)
`define SWU_OFM_H (((`SWU_IFM_H - `SWU_K) / `SWU_STRIDE) + 1)
`define SWU_FRAME_WORDS (`SWU_IFM_W * `SWU_IFM_H * `SWU_EFF_CH)

`endif

// ==== design/swu_pkg.sv ====
`include "swu_config.svh"

package swu_pkg;

   ////////////////////
   // shared types
   ////////////////////

   // one input word with SIMD channels packed side by side
   typedef logic [`SWU_SIMD*`SWU_PREC-1:0] swu_word_t;

   // location inside the circular buffer
   typedef logic [$clog2(`SWU_BUF_SIZE)-1:0] swu_addr_t;

   // absolute word number within a frame
   // sized for frame words plus one buffer of headroom
   // so the free-space sum never overflows
   typedef logic [$clog2(`SWU_FRAME_WORDS + `SWU_BUF_SIZE)-1:0] swu_idx_t;

endpackage

// ==== design/swu_pixel_writer.sv ====
`timescale 1ns/1ns
`include "swu_config.svh"

module swu_pixel_writer
   import swu_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   // input stream
   input  swu_word_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   // feedback from the window reader
   input  swu_idx_t  release_idx_i,
   input  logic      frame_done_i,
   // buffer write port
   output logic      wr_en_o,
   output swu_addr_t wr_addr_o,
   output swu_word_t wr_data_o,
   // words accepted so far in this frame
   output swu_idx_t  wr_count_o
);

   localparam swu_idx_t  BUF_WORDS   = swu_idx_t'(`SWU_BUF_SIZE);
   localparam swu_idx_t  FRAME_WORDS = swu_idx_t'(`SWU_FRAME_WORDS);
   localparam swu_addr_t LAST_ADDR   = swu_addr_t'(`SWU_BUF_SIZE - 1);

   swu_idx_t  count_q;
   swu_addr_t addr_q;
   logic      below_release;
   logic      below_frame;
   logic      accept;

   ////////////////////
   // free-space rule
   ////////////////////

   // never overwrite a word the current window row still needs
   assign below_release = count_q < (release_idx_i + BUF_WORDS);
   // stop once the whole frame is in
   assign below_frame   = count_q < FRAME_WORDS;

   assign in_ready_o = below_release && below_frame;
   assign accept     = in_valid_i && in_ready_o;

   // accepted word goes straight into the buffer
   assign wr_en_o    = accept;
   assign wr_addr_o  = addr_q;
   assign wr_data_o  = in_data_i;
   assign wr_count_o = count_q;

   ////////////////////
   // count and address
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= '0;
         addr_q  <= '0;
      end else if (frame_done_i) begin
         // next frame starts at index 0 and address 0
         count_q <= '0;
         addr_q  <= '0;
      end else if (accept) begin
         count_q <= count_q + 1'b1;
         if (addr_q == LAST_ADDR) begin
            addr_q <= '0;
         end else begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

endmodule

// ==== design/swu_window_ram.sv ====
`timescale 1ns/1ns
`include "swu_config.svh"

module swu_window_ram
   import swu_pkg::*;
(
   input  logic      clk,
   // write side from the pixel writer
   input  logic      wr_en_i,
   input  swu_addr_t wr_addr_i,
   input  swu_word_t wr_data_i,
   // read side from the window reader
   input  logic      rd_en_i,
   input  swu_addr_t rd_addr_i,
   output swu_word_t rd_data_o
);

   swu_word_t mem [`SWU_BUF_SIZE];
   swu_word_t rd_data_q;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // output register keeps its word while the reader is stalled
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

// ==== design/swu_window_reader.sv ====
`timescale 1ns/1ns
`include "swu_config.svh"

module swu_window_reader
   import swu_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   // progress of the pixel writer
   input  swu_idx_t  wr_count_i,
   // buffer read port
   output logic      rd_en_o,
   output swu_addr_t rd_addr_o,
   input  swu_word_t rd_data_i,
   // feedback to the pixel writer
   output swu_idx_t  release_idx_o,
   output logic      frame_done_o,
   // window stream
   output swu_word_t out_data_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);

   localparam int EFF_CH    = `SWU_EFF_CH;
   localparam int CH_W      = (EFF_CH > 1) ? $clog2(EFF_CH) : 1;
   localparam int K_W       = (`SWU_K > 1) ? $clog2(`SWU_K) : 1;
   localparam int OC_W      = (`SWU_OFM_W > 1) ? $clog2(`SWU_OFM_W) : 1;
   localparam int OR_W      = (`SWU_OFM_H > 1) ? $clog2(`SWU_OFM_H) : 1;
   localparam int ROW_WORDS = `SWU_STRIDE * `SWU_IFM_W * EFF_CH;

   localparam logic [CH_W-1:0] CH_MAX = CH_W'(EFF_CH - 1);
   localparam logic [K_W-1:0]  K_MAX  = K_W'(`SWU_K - 1);
   localparam logic [OC_W-1:0] OC_MAX = OC_W'(`SWU_OFM_W - 1);
   localparam logic [OR_W-1:0] OR_MAX = OR_W'(`SWU_OFM_H - 1);

   // window position with the innermost counter first
   logic [CH_W-1:0] ch_q;
   logic [K_W-1:0]  kw_q;
   logic [K_W-1:0]  kh_q;
   logic [OC_W-1:0] oc_q;
   logic [OR_W-1:0] or_q;

   // set once the last word of the frame has been issued
   logic issued_all_q;

   logic ch_wrap;
   logic kw_wrap;
   logic kh_wrap;
   logic oc_wrap;
   logic frame_last;

   swu_idx_t in_row;
   swu_idx_t in_col;
   swu_idx_t cur_idx;

   logic can_adv;
   logic present;
   logic issue;
   logic frame_done;

   // issue stage (RAM output register) and output stage
   logic      r_valid_q;
   logic      r_last_q;
   logic      q_valid_q;
   logic      q_last_q;
   swu_word_t out_data_q;

   ////////////////////
   // address generation
   ////////////////////

   always_comb begin
      in_row  = swu_idx_t'(or_q * `SWU_STRIDE + kh_q);
      in_col  = swu_idx_t'(oc_q * `SWU_STRIDE + kw_q);
      cur_idx = swu_idx_t'((in_row * `SWU_IFM_W + in_col) * EFF_CH + ch_q);
   end

   assign rd_addr_o = swu_addr_t'(cur_idx % `SWU_BUF_SIZE);

   // first word of the top input row of this window row
   assign release_idx_o = swu_idx_t'(or_q * ROW_WORDS);

   ////////////////////
   // issue control
   ////////////////////

   // whole pipeline moves together and stalls only on output back-pressure
   assign can_adv = out_ready_i || !q_valid_q;
   // word already written by the pixel writer
   assign present = cur_idx < wr_count_i;
   assign issue   = can_adv && present && !issued_all_q;
   assign rd_en_o = issue;

   assign ch_wrap    = (ch_q == CH_MAX);
   assign kw_wrap    = ch_wrap && (kw_q == K_MAX);
   assign kh_wrap    = kw_wrap && (kh_q == K_MAX);
   assign oc_wrap    = kh_wrap && (oc_q == OC_MAX);
   assign frame_last = oc_wrap && (or_q == OR_MAX);

   // last window word handed over downstream
   assign frame_done   = q_valid_q && q_last_q && out_ready_i;
   assign frame_done_o = frame_done;

   ////////////////////
   // window counters
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done) begin
         ch_q         <= '0;
         kw_q         <= '0;
         kh_q         <= '0;
         oc_q         <= '0;
         or_q         <= '0;
         issued_all_q <= 1'b0;
      end else if (issue) begin
         if (frame_last) begin
            // hold position until the pipeline drains
            issued_all_q <= 1'b1;
         end else begin
            if (ch_wrap) begin
               ch_q <= '0;
            end else begin
               ch_q <= ch_q + 1'b1;
            end
            if (kw_wrap) begin
               kw_q <= '0;
            end else if (ch_wrap) begin
               kw_q <= kw_q + 1'b1;
            end
            if (kh_wrap) begin
               kh_q <= '0;
            end else if (kw_wrap) begin
               kh_q <= kh_q + 1'b1;
            end
            if (oc_wrap) begin
               oc_q <= '0;
               or_q <= or_q + 1'b1;
            end else if (kh_wrap) begin
               oc_q <= oc_q + 1'b1;
            end
         end
      end
   end

   ////////////////////
   // output pipeline
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         r_valid_q <= 1'b0;
         r_last_q  <= 1'b0;
         q_valid_q <= 1'b0;
         q_last_q  <= 1'b0;
      end else if (can_adv) begin
         r_valid_q <= issue;
         r_last_q  <= issue && frame_last;
         q_valid_q <= r_valid_q;
         q_last_q  <= r_last_q;
      end
   end

   always_ff @(posedge clk) begin
      if (can_adv) begin
         out_data_q <= rd_data_i;
      end
   end

   assign out_data_o  = out_data_q;
   assign out_valid_o = q_valid_q;

endmodule

// ==== design/swu_top.sv ====
`timescale 1ns/1ns
`include "swu_config.svh"

module swu_top
   import swu_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   // input feature-map words
   input  swu_word_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   // window words
   output swu_word_t out_data_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);

   // writer to RAM
   logic      wr_en;
   swu_addr_t wr_addr;
   swu_word_t wr_data;

   // reader to RAM and back
   logic      rd_en;
   swu_addr_t rd_addr;
   swu_word_t rd_data;

   // flow control between writer and reader
   swu_idx_t  wr_count;
   swu_idx_t  release_idx;
   logic      frame_done;

   swu_pixel_writer u_writer (
      .clk           (clk),
      .resetn        (resetn),
      .in_data_i     (in_data_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .release_idx_i (release_idx),
      .frame_done_i  (frame_done),
      .wr_en_o       (wr_en),
      .wr_addr_o     (wr_addr),
      .wr_data_o     (wr_data),
      .wr_count_o    (wr_count)
   );

   swu_window_ram u_ram (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   swu_window_reader u_reader (
      .clk           (clk),
      .resetn        (resetn),
      .wr_count_i    (wr_count),
      .rd_en_o       (rd_en),
      .rd_addr_o     (rd_addr),
      .rd_data_i     (rd_data),
      .release_idx_o (release_idx),
      .frame_done_o  (frame_done),
      .out_data_o    (out_data_o),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i)
   );

endmodule

// ==== bench/swu_tb.sv ====
`timescale 1ns/1ns
`include "swu_config.svh"

module swu_tb
   import swu_pkg::*;
();

   localparam int NUM_TESTS   = 5;
   localparam int MAX_FRAMES  = 3;
   localparam int FRAME_WORDS = `SWU_FRAME_WORDS;
   localparam int WIN_WORDS   = `SWU_OFM_H * `SWU_OFM_W * `SWU_K * `SWU_K * `SWU_EFF_CH;
   localparam int S           = `SWU_STRIDE;
   localparam int W           = `SWU_IFM_W;
   localparam int E           = `SWU_EFF_CH;
   // cycles of input stall before output is released
   localparam int HOLD_CYCLES = 20;

   logic      clk = 1'b0;
   logic      resetn;
   swu_word_t in_data;
   logic      in_valid;
   logic      in_ready;
   swu_word_t out_data;
   logic      out_valid;
   logic      out_ready;

   ////////////////////
   // stimulus table
   ////////////////////

   // one entry per test
   // duty values are thresholds out of 16
   string tab_name [NUM_TESTS] = '{
      "window_order", "out_backpressure", "in_gaps", "free_space", "frame_restart"
   };
   int    tab_frames   [NUM_TESTS] = '{1, 1, 1, 1, 3};
   int    tab_in_duty  [NUM_TESTS] = '{16, 16, 6, 16, 10};
   int    tab_out_duty [NUM_TESTS] = '{16, 8, 16, 16, 10};
   // hold out_ready low until the input side stalls
   bit    tab_hold     [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

   logic [31:0] rng_state = 32'd33495;
   swu_word_t   in_words [MAX_FRAMES*FRAME_WORDS];
   swu_word_t   exp_q [$];
   string       cur_name;
   int          test_errs;
   int          err_count = 0;
   int          tests_failed = 0;

   swu_top u_swu_top (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   always #50 clk = ~clk;

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // true with probability threshold / 16
   function automatic logic coin(input int threshold);
      rng_state = xorshift32(rng_state);
      return int'(rng_state[3:0]) < threshold;
   endfunction

   function automatic int budget_cycles();
      int sum;
      sum = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         sum += 8 * tab_frames[t] * (FRAME_WORDS + WIN_WORDS);
      end
      return sum;
   endfunction

   task automatic check_word(input int pos, input swu_word_t expected, input swu_word_t actual);
      if (actual !== expected) begin
         $display("FAIL %s word %0d: expected %h, actual %h", cur_name, pos, expected, actual);
         test_errs++;
      end
   endtask

   task automatic check_count(input swu_idx_t expected, input swu_idx_t actual);
      if (actual !== expected) begin
         $display("FAIL %s accepted words: expected %0d, actual %0d",
                  cur_name, expected, actual);
         test_errs++;
      end
   endtask

   // window order is out row, out col, kernel row, kernel col, channel group
   task automatic build_expected(input int frames);
      int base;
      int idx;
      exp_q.delete();
      for (int f = 0; f < frames; f++) begin
         base = f * FRAME_WORDS;
         for (int r = 0; r < `SWU_OFM_H; r++)
            for (int c = 0; c < `SWU_OFM_W; c++)
               for (int i = 0; i < `SWU_K; i++)
                  for (int j = 0; j < `SWU_K; j++)
                     for (int g = 0; g < E; g++) begin
                        idx = ((r*S + i)*W + c*S + j)*E + g;
                        exp_q.push_back(in_words[base + idx]);
                     end
      end
   endtask

   task automatic apply_reset();
      resetn    = 1'b0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      repeat (2) @(negedge clk);
      resetn = 1'b1;
   endtask

   ////////////////////
   // one test
   ////////////////////

   task automatic run_test(input int t);
      int   total_in;
      int   total_out;
      int   n_in;
      int   n_out;
      int   stall;
      logic hold;
      logic in_taken;
      logic ready_check;
      cur_name  = tab_name[t];
      test_errs = 0;
      total_in  = tab_frames[t] * FRAME_WORDS;
      total_out = tab_frames[t] * WIN_WORDS;
      for (int k = 0; k < total_in; k++) begin
         rng_state   = xorshift32(rng_state);
         in_words[k] = swu_word_t'(rng_state);
      end
      build_expected(tab_frames[t]);
      apply_reset();
      n_in        = 0;
      n_out       = 0;
      stall       = 0;
      hold        = tab_hold[t];
      in_taken    = 1'b0;
      ready_check = 1'b0;
      // every pass of the loop sits on a falling edge
      while (n_out < total_out || ready_check) begin
         if (ready_check) begin
            if (!in_ready) begin
               $display("%s: in_ready_o did not return high after a frame ended", cur_name);
               test_errs++;
            end
            ready_check = 1'b0;
         end
         // new word only once the previous one was taken
         if (!in_valid || in_taken) begin
            if (n_in < total_in) begin
               in_valid = coin(tab_in_duty[t]);
               in_data  = in_words[n_in];
            end else begin
               in_valid = 1'b0;
            end
         end
         in_taken = in_valid && in_ready;
         if (in_taken) begin
            n_in++;
         end
         if (hold) begin
            out_ready = 1'b0;
            if (in_valid && !in_ready) stall++;
            else stall = 0;
            if (stall >= HOLD_CYCLES) begin
               check_count(swu_idx_t'(`SWU_BUF_SIZE), swu_idx_t'(n_in));
               hold = 1'b0;
            end
         end else begin
            out_ready = coin(tab_out_duty[t]);
         end
         if (out_valid && out_ready) begin
            if (n_out < total_out) begin
               check_word(n_out, exp_q[n_out], out_data);
               n_out++;
               if (n_out % WIN_WORDS == 0) ready_check = 1'b1;
            end else begin
               $display("%s: output word arrived after the last expected one", cur_name);
               test_errs++;
            end
         end
         @(negedge clk);
      end
      in_valid  = 1'b0;
      out_ready = 1'b0;
      $display("test %s: %0d frames, %0d words checked, %0d errors",
               cur_name, tab_frames[t], n_out, test_errs);
      err_count += test_errs;
      if (test_errs != 0) tests_failed++;
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      resetn    = 1'b0;
      in_data   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, tests_failed, err_count);
      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog sized from the table
   initial begin : watchdog
      int cycles;
      int limit;
      cycles = 0;
      limit  = budget_cycles();
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== swu_top.f ====
+incdir+design
design/swu_pkg.sv
design/swu_pixel_writer.sv
design/swu_window_ram.sv
design/swu_window_reader.sv
design/swu_top.sv
bench/swu_tb.sv

// ==== Makefile ====
# Verilator simulation of the sliding-window unit

VERILATOR   = verilator
TOP         = swu_tb
RTL_TOP     = swu_top
FILELIST    = swu_top.f
BUILD_FLAGS = --binary --timing
LINT_FLAGS  = --lint-only -Wall --timing
OBJ_DIR     = obj_dir
LOG         = sim.log
PASS_MSG    = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
